// ==== logic/dm_config.svh ====
`ifndef DM_CONFIG_SVH
`define DM_CONFIG_SVH

// dmi field widths
`define DM_ADDR_W           6
`define DM_DATA_W           32
`define DM_OP_W             2
`define DM_REQ_W            (`DM_ADDR_W + `DM_DATA_W + `DM_OP_W)

// hart register file index
`define DM_GPR_ADDR_W       5
`define DM_GPR_BASE         16'h1000
`define DM_GPR_LIMIT        16'h1020

// dmcontrol write shaping
`define DM_DMCONTROL_MASK   32'h003f_ffc0
`define DM_DMCONTROL_SET    32'h0001_0000

// register reset values
`define DM_DMSTATUS_RST     32'h0043_0c82
`define DM_ABSTRACTCS_RST   32'h0100_0003
`define DM_SBCS_RST         32'h2004_0404

// cmderr field of abstractcs
`define DM_CMDERR_UNSUP     32'h0000_0200
`define DM_CMDERR_MASK      32'h0000_0700

// dmstatus bits 11:8 as allhalted/anyhalted or allrunning/anyrunning
`define DM_STATUS_HALTED    4'h3
`define DM_STATUS_RUNNING   4'hc

// system bus
`define DM_SB_STEP          32'd4
`define DM_SBCS_AUTOINC_BIT 16
`define DM_SBCS_RDONADDR_BIT 20

`endif

// ==== logic/dm_pkg.sv ====
`include "dm_config.svh"

package dm_pkg;

    // dmi operation field
    typedef enum logic [`DM_OP_W-1:0] {
        DMI_OP_NOP   = 2'b00,
        DMI_OP_READ  = 2'b01,
        DMI_OP_WRITE = 2'b10
    } dmi_op_e;

    // debug module register map
    typedef enum logic [`DM_ADDR_W-1:0] {
        DM_DATA0      = 6'h04,
        DM_DMCONTROL  = 6'h10,
        DM_DMSTATUS   = 6'h11,
        DM_HARTINFO   = 6'h12,
        DM_ABSTRACTCS = 6'h16,
        DM_COMMAND    = 6'h17,
        DM_SBCS       = 6'h38,
        DM_SBADDRESS0 = 6'h39,
        DM_SBDATA0    = 6'h3c
    } dm_addr_e;

    // transaction FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXE,
        ST_RESP
    } dm_state_e;

    // request word as sent by the DTM with the address in the top bits
    typedef struct packed {
        logic [`DM_ADDR_W-1:0] addr;
        logic [`DM_DATA_W-1:0] data;
        dmi_op_e               op;
    } dmi_req_t;

    typedef logic [`DM_DATA_W-1:0] dm_status_t;

endpackage

// ==== logic/dmi_cmd_if.sv ====
`timescale 1ns/1ps

interface dmi_cmd_if
    import dm_pkg::*;
();

    // captured request held from acceptance to the next one
    dmi_req_t req;
    // one cycle in the exe state
    logic     exe;
    // resp cycle where the core has answered
    logic     core_done;

    modport decode (
        output req,
        output exe,
        output core_done
    );

    modport exec (
        input req,
        input exe,
        input core_done
    );

    modport result (
        input req,
        input exe,
        input core_done
    );

endinterface

// ==== logic/dm_csr_if.sv ====
`timescale 1ns/1ps

interface dm_csr_if
    import dm_pkg::*;
();

    dm_status_t dmstatus;
    dm_status_t dmcontrol;
    dm_status_t abstractcs;
    dm_status_t sbcs;
    dm_status_t data0;
    // a gpr read result waits to be returned through data0
    logic       gpr_rd_pend;

    modport exec (
        output dmstatus, dmcontrol, abstractcs, sbcs, data0, gpr_rd_pend
    );

    modport result (
        input dmstatus, dmcontrol, abstractcs, sbcs, data0, gpr_rd_pend
    );

endinterface

// ==== logic/dmi_decode.sv ====
`timescale 1ns/1ps

`include "dm_config.svh"

module dmi_decode
    import dm_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             dtm_req_valid_i,
    input  dmi_req_t         dtm_req_i,
    input  logic             dm_resp_ready_i,
    dmi_cmd_if.decode        cmd,
    output logic             dm_busy_o,
    output logic             dm_op_req_o
);

    dm_state_e state;
    dm_state_e state_next;
    dmi_req_t  req_q;
    logic      req_accept;
    logic      access_local;
    logic      access_core;

    // requests are only looked at while idle
    assign req_accept = (state == ST_IDLE) && dtm_req_valid_i;

    always_ff @(posedge clk) begin
        if (req_accept) begin
            req_q <= dtm_req_i;
        end
    end

    // dmcontrol, dmstatus and hartinfo are served without the core
    assign access_local = (req_q.addr == DM_DMCONTROL) ||
                          (req_q.addr == DM_DMSTATUS)  ||
                          (req_q.addr == DM_HARTINFO);
    assign access_core  = (req_q.op != DMI_OP_NOP) && !access_local;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (req_accept) begin
                    state_next = ST_EXE;
                end
            end
            ST_EXE: begin
                if (access_core) begin
                    state_next = ST_RESP;
                end else begin
                    state_next = ST_IDLE;
                end
            end
            ST_RESP: begin
                // hold until the core side says ready
                if (dm_resp_ready_i) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    assign cmd.req       = req_q;
    assign cmd.exe       = (state == ST_EXE);
    assign cmd.core_done = (state == ST_RESP) && dm_resp_ready_i;

    assign dm_busy_o   = (state != ST_IDLE);
    assign dm_op_req_o = (state == ST_RESP);

endmodule

// ==== logic/dm_debug_regs.sv ====
`timescale 1ns/1ps

`include "dm_config.svh"

module dm_debug_regs
    import dm_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    dmi_cmd_if.exec                   cmd,
    dm_csr_if.exec                    csr,
    output logic                      dm_halt_req_o,
    output logic                      dm_reg_we_o,
    output logic [`DM_GPR_ADDR_W-1:0] dm_reg_addr_o,
    output dm_status_t                dm_reg_wdata_o,
    output logic                      dm_mem_we_o,
    output dm_status_t                dm_mem_addr_o,
    output dm_status_t                dm_mem_wdata_o
);

    dm_status_t                dmcontrol;
    dm_status_t                dmstatus;
    dm_status_t                abstractcs;
    dm_status_t                data0;
    dm_status_t                sbcs;
    dm_status_t                sbaddress0;
    logic                      halt_req;
    logic                      gpr_rd_pend;
    logic                      reg_we;
    logic [`DM_GPR_ADDR_W-1:0] reg_addr;
    dm_status_t                reg_wdata;
    logic                      mem_we;
    dm_status_t                mem_addr;
    dm_status_t                mem_wdata;

    dm_status_t                wdata;
    logic                      op_write;
    logic                      op_read;
    logic                      wr_dmcontrol;
    logic                      dm_reset;
    logic                      wr_command;
    logic                      cmd_is_reg;
    logic [2:0]                aarsize;
    logic [15:0]               regno;
    logic [15:0]               gpr_off;
    logic                      gpr_cmd;
    logic                      sb_access;

    assign wdata    = cmd.req.data;
    assign op_write = cmd.exe && (cmd.req.op == DMI_OP_WRITE);
    assign op_read  = cmd.exe && (cmd.req.op == DMI_OP_READ);

    assign wr_dmcontrol = op_write && (cmd.req.addr == DM_DMCONTROL);
    // clearing dmactive resets the whole module
    assign dm_reset     = wr_dmcontrol && !wdata[0];

    // abstract command fields: cmdtype, aarsize, transfer, write, regno
    assign wr_command = op_write && (cmd.req.addr == DM_COMMAND);
    assign cmd_is_reg = (wdata[31:24] == 8'h0);
    assign aarsize    = wdata[22:20];
    assign regno      = wdata[15:0];
    assign gpr_off    = regno - `DM_GPR_BASE;
    assign gpr_cmd    = wr_command && cmd_is_reg && (aarsize <= 3'd2) && wdata[17] &&
                        (regno >= `DM_GPR_BASE) && (regno < `DM_GPR_LIMIT);

    assign sb_access = (op_write || op_read) && (cmd.req.addr == DM_SBDATA0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmcontrol <= '0;
        end else if (dm_reset) begin
            dmcontrol <= wdata;
        end else if (wr_dmcontrol) begin
            dmcontrol <= (wdata & ~`DM_DMCONTROL_MASK) | `DM_DMCONTROL_SET;
        end
    end

    // halt and resume requests
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dmstatus <= `DM_DMSTATUS_RST;
            halt_req <= 1'b0;
        end else if (dm_reset) begin
            dmstatus <= `DM_DMSTATUS_RST;
            halt_req <= 1'b0;
        end else if (wr_dmcontrol) begin
            if (wdata[31]) begin
                halt_req       <= 1'b1;
                dmstatus[11:8] <= `DM_STATUS_HALTED;
            end else if (halt_req && wdata[30]) begin
                halt_req       <= 1'b0;
                dmstatus[11:8] <= `DM_STATUS_RUNNING;
            end
        end
    end

    // cmderr only reports unsupported access sizes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            abstractcs <= `DM_ABSTRACTCS_RST;
        end else if (dm_reset) begin
            abstractcs <= `DM_ABSTRACTCS_RST;
        end else if (wr_command && cmd_is_reg) begin
            if (aarsize > 3'd2) begin
                abstractcs <= abstractcs | `DM_CMDERR_UNSUP;
            end else begin
                abstractcs <= abstractcs & ~`DM_CMDERR_MASK;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data0 <= '0;
            sbcs  <= `DM_SBCS_RST;
        end else if (dm_reset) begin
            data0 <= '0;
            sbcs  <= `DM_SBCS_RST;
        end else begin
            if (op_write && (cmd.req.addr == DM_DATA0)) begin
                data0 <= wdata;
            end
            if (op_write && (cmd.req.addr == DM_SBCS)) begin
                sbcs <= wdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sbaddress0 <= '0;
        end else if (dm_reset) begin
            sbaddress0 <= '0;
        end else if (op_write && (cmd.req.addr == DM_SBADDRESS0)) begin
            sbaddress0 <= wdata;
        end else if (sb_access && sbcs[`DM_SBCS_AUTOINC_BIT]) begin
            sbaddress0 <= sbaddress0 + `DM_SB_STEP;
        end
    end

    // write enables span the resp cycles of their transaction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_we      <= 1'b0;
            gpr_rd_pend <= 1'b0;
            mem_we      <= 1'b0;
        end else if (dm_reset) begin
            reg_we      <= 1'b0;
            gpr_rd_pend <= 1'b0;
            mem_we      <= 1'b0;
        end else begin
            if (gpr_cmd && wdata[16]) begin
                reg_we <= 1'b1;
            end else if (cmd.core_done) begin
                reg_we <= 1'b0;
            end
            if (gpr_cmd && !wdata[16]) begin
                gpr_rd_pend <= 1'b1;
            end else if (op_read && (cmd.req.addr == DM_DATA0)) begin
                gpr_rd_pend <= 1'b0;
            end
            if (op_write && (cmd.req.addr == DM_SBDATA0)) begin
                mem_we <= 1'b1;
            end else if (cmd.core_done) begin
                mem_we <= 1'b0;
            end
        end
    end

    // hart and bus payload
    always_ff @(posedge clk) begin
        if (gpr_cmd) begin
            reg_addr <= gpr_off[`DM_GPR_ADDR_W-1:0];
            if (wdata[16]) begin
                reg_wdata <= data0;
            end
        end
        if (op_write && (cmd.req.addr == DM_SBDATA0)) begin
            mem_addr  <= sbaddress0;
            mem_wdata <= wdata;
        end else if (op_write && (cmd.req.addr == DM_SBADDRESS0) &&
                     sbcs[`DM_SBCS_RDONADDR_BIT]) begin
            // sbreadonaddr
            mem_addr <= wdata;
        end
    end

    assign csr.dmstatus    = dmstatus;
    assign csr.dmcontrol   = dmcontrol;
    assign csr.abstractcs  = abstractcs;
    assign csr.sbcs        = sbcs;
    assign csr.data0       = data0;
    assign csr.gpr_rd_pend = gpr_rd_pend;

    assign dm_halt_req_o  = halt_req;
    assign dm_reg_we_o    = reg_we;
    assign dm_reg_addr_o  = reg_addr;
    assign dm_reg_wdata_o = reg_wdata;
    assign dm_mem_we_o    = mem_we;
    assign dm_mem_addr_o  = mem_addr;
    assign dm_mem_wdata_o = mem_wdata;

endmodule

// ==== logic/dm_resp.sv ====
`timescale 1ns/1ps

`include "dm_config.svh"

module dm_resp
    import dm_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    dmi_cmd_if.result            cmd,
    dm_csr_if.result             csr,
    input  dm_status_t           dm_reg_rdata_i,
    input  dm_status_t           dm_mem_rdata_i,
    output logic [`DM_REQ_W-1:0] dm_resp_data_o
);

    localparam logic [`DM_OP_W-1:0] OP_SUCCESS = '0;

    dm_status_t reg_rdata;
    dm_status_t mem_rdata;
    dm_status_t rd_sel;
    dm_status_t rdata;

    // core read data is held until a later data0 or sbdata0 read
    always_ff @(posedge clk) begin
        if (cmd.core_done) begin
            reg_rdata <= dm_reg_rdata_i;
            mem_rdata <= dm_mem_rdata_i;
        end
    end

    always_comb begin
        rd_sel = '0;
        if (cmd.req.op == DMI_OP_READ) begin
            case (cmd.req.addr)
                DM_DMSTATUS:   rd_sel = csr.dmstatus;
                DM_DMCONTROL:  rd_sel = csr.dmcontrol;
                DM_SBCS:       rd_sel = csr.sbcs;
                DM_ABSTRACTCS: rd_sel = csr.abstractcs;
                DM_DATA0:      rd_sel = csr.gpr_rd_pend ? reg_rdata : csr.data0;
                DM_SBDATA0:    rd_sel = mem_rdata;
                default:       rd_sel = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (cmd.exe) begin
            rdata <= rd_sel;
        end
    end

    assign dm_resp_data_o = {cmd.req.addr, rdata, OP_SUCCESS};

endmodule

// ==== logic/riscv_dm_top.sv ====
`timescale 1ns/1ps

`include "dm_config.svh"

module riscv_dm_top
    import dm_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    // DTM side
    input  logic                      dtm_req_valid_i,
    input  logic [`DM_REQ_W-1:0]      dtm_req_data_i,
    output logic                      dm_busy_o,
    output logic [`DM_REQ_W-1:0]      dm_resp_data_o,
    input  logic                      dm_resp_ready_i,
    // hart register port
    output logic                      dm_reg_we_o,
    output logic [`DM_GPR_ADDR_W-1:0] dm_reg_addr_o,
    output logic [`DM_DATA_W-1:0]     dm_reg_wdata_o,
    input  logic [`DM_DATA_W-1:0]     dm_reg_rdata_i,
    // system bus port
    output logic                      dm_mem_we_o,
    output logic [`DM_DATA_W-1:0]     dm_mem_addr_o,
    output logic [`DM_DATA_W-1:0]     dm_mem_wdata_o,
    input  logic [`DM_DATA_W-1:0]     dm_mem_rdata_i,
    output logic                      dm_op_req_o,
    output logic                      dm_halt_req_o
);

    dmi_req_t dtm_req;

    dmi_cmd_if cmd_bus ();
    dm_csr_if  csr_bus ();

    assign dtm_req = dmi_req_t'(dtm_req_data_i);

    dmi_decode u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .dtm_req_valid_i (dtm_req_valid_i),
        .dtm_req_i       (dtm_req),
        .dm_resp_ready_i (dm_resp_ready_i),
        .cmd             (cmd_bus.decode),
        .dm_busy_o       (dm_busy_o),
        .dm_op_req_o     (dm_op_req_o)
    );

    dm_debug_regs u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd            (cmd_bus.exec),
        .csr            (csr_bus.exec),
        .dm_halt_req_o  (dm_halt_req_o),
        .dm_reg_we_o    (dm_reg_we_o),
        .dm_reg_addr_o  (dm_reg_addr_o),
        .dm_reg_wdata_o (dm_reg_wdata_o),
        .dm_mem_we_o    (dm_mem_we_o),
        .dm_mem_addr_o  (dm_mem_addr_o),
        .dm_mem_wdata_o (dm_mem_wdata_o)
    );

    dm_resp u_resp (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd            (cmd_bus.result),
        .csr            (csr_bus.result),
        .dm_reg_rdata_i (dm_reg_rdata_i),
        .dm_mem_rdata_i (dm_mem_rdata_i),
        .dm_resp_data_o (dm_resp_data_o)
    );

endmodule

// ==== verif/riscv_dm_tb.sv ====
`timescale 1ns/1ps

`include "dm_config.svh"

module riscv_dm_tb
    import dm_pkg::*;
();

    localparam int WAIT_LIMIT = 50;

    integer seed = 47353;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      dtm_req_valid;
    logic [`DM_REQ_W-1:0]      dtm_req_data;
    logic                      dm_busy;
    logic [`DM_REQ_W-1:0]      resp_data;
    logic                      resp_ready;
    logic                      reg_we;
    logic [`DM_GPR_ADDR_W-1:0] reg_addr;
    dm_status_t                reg_wdata;
    dm_status_t                reg_rdata;
    logic                      mem_we;
    dm_status_t                mem_addr;
    dm_status_t                mem_wdata;
    dm_status_t                mem_rdata;
    logic                      op_req;
    logic                      halt_req;

    // hart register file and a small memory read combinationally
    dm_status_t regs [0:31];
    dm_status_t mem  [0:63];

    // shadow state of the debug module
    dm_status_t sh_dmcontrol;
    dm_status_t sh_dmstatus;
    dm_status_t sh_abstractcs;
    dm_status_t sh_data0;
    dm_status_t sh_sbcs;
    dm_status_t sh_sbaddress0;
    dm_status_t sh_mem_addr;
    logic       sh_pend;
    logic       sh_halt;
    logic [4:0] sh_gpr_idx;

    logic [`DM_REQ_W-1:0]      exp_q [$];
    logic                      exp_halt_q [$];
    event                      resp_done;
    int                        busy_cycles;
    logic                      seen_reg_we;
    logic [`DM_GPR_ADDR_W-1:0] seen_reg_addr;
    dm_status_t                seen_reg_wdata;
    logic                      seen_mem_we;
    dm_status_t                seen_mem_addr;
    dm_status_t                seen_mem_wdata;
    dm_status_t                wval [0:2];

    riscv_dm_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .dtm_req_valid_i (dtm_req_valid),
        .dtm_req_data_i  (dtm_req_data),
        .dm_busy_o       (dm_busy),
        .dm_resp_data_o  (resp_data),
        .dm_resp_ready_i (resp_ready),
        .dm_reg_we_o     (reg_we),
        .dm_reg_addr_o   (reg_addr),
        .dm_reg_wdata_o  (reg_wdata),
        .dm_reg_rdata_i  (reg_rdata),
        .dm_mem_we_o     (mem_we),
        .dm_mem_addr_o   (mem_addr),
        .dm_mem_wdata_o  (mem_wdata),
        .dm_mem_rdata_i  (mem_rdata),
        .dm_op_req_o     (op_req),
        .dm_halt_req_o   (halt_req)
    );

    always #4 clk = ~clk;

    assign reg_rdata = regs[reg_addr];
    assign mem_rdata = mem[mem_addr[7:2]];

    // writes land on the edge where ready is seen
    always @(posedge clk) begin
        if (resp_ready && reg_we) begin
            regs[reg_addr] <= reg_wdata;
        end
        if (resp_ready && mem_we) begin
            mem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic give_up(input string why);
        $display("Error: %s", why);
        stop_run();
    endtask

    task automatic check_resp(input string name, input logic [`DM_REQ_W-1:0] act,
                              input logic [`DM_REQ_W-1:0] exp);
        if (act !== exp) begin
            $display("Fail %s: got %h, expected %h", name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input dm_status_t act, input dm_status_t exp);
        if (act !== exp) begin
            $display("Fail %s: got %h, expected %h", name, act, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail %s: got %h, expected %h", name, act, exp);
            stop_run();
        end
    endtask

    // expected response word; updates the shadow state as a side effect
    function automatic logic [`DM_REQ_W-1:0] ref_resp(input dmi_req_t req);
        dm_status_t  rd;
        dm_status_t  d;
        logic [15:0] regno;
        rd    = '0;
        d     = req.data;
        regno = d[15:0];
        if (req.op == DMI_OP_READ) begin
            case (req.addr)
                DM_DMSTATUS:   rd = sh_dmstatus;
                DM_DMCONTROL:  rd = sh_dmcontrol;
                DM_SBCS:       rd = sh_sbcs;
                DM_ABSTRACTCS: rd = sh_abstractcs;
                DM_DATA0: begin
                    rd      = sh_pend ? regs[sh_gpr_idx] : sh_data0;
                    sh_pend = 1'b0;
                end
                DM_SBDATA0: begin
                    rd = mem[sh_mem_addr[7:2]];
                    if (sh_sbcs[`DM_SBCS_AUTOINC_BIT]) begin
                        sh_sbaddress0 = sh_sbaddress0 + `DM_SB_STEP;
                    end
                end
                default: rd = '0;
            endcase
        end else if (req.op == DMI_OP_WRITE) begin
            case (req.addr)
                DM_DMCONTROL: begin
                    if (!d[0]) begin
                        // dmactive low puts the whole module back in reset
                        sh_dmcontrol  = d;
                        sh_dmstatus   = `DM_DMSTATUS_RST;
                        sh_abstractcs = `DM_ABSTRACTCS_RST;
                        sh_sbcs       = `DM_SBCS_RST;
                        sh_data0      = '0;
                        sh_sbaddress0 = '0;
                        sh_pend       = 1'b0;
                        sh_halt       = 1'b0;
                    end else begin
                        sh_dmcontrol = (d & ~`DM_DMCONTROL_MASK) | `DM_DMCONTROL_SET;
                        if (d[31]) begin
                            sh_halt            = 1'b1;
                            sh_dmstatus[11:8]  = 4'h3;
                        end else if (sh_halt && d[30]) begin
                            sh_halt            = 1'b0;
                            sh_dmstatus[11:8]  = 4'hc;
                        end
                    end
                end
                DM_COMMAND: begin
                    if (d[31:24] == 8'h0) begin
                        if (d[22:20] > 3'd2) begin
                            sh_abstractcs = sh_abstractcs | `DM_CMDERR_UNSUP;
                        end else begin
                            sh_abstractcs = sh_abstractcs & ~`DM_CMDERR_MASK;
                            if (d[17] && regno >= `DM_GPR_BASE && regno < `DM_GPR_LIMIT) begin
                                sh_gpr_idx = 5'(regno - `DM_GPR_BASE);
                                if (!d[16]) begin
                                    sh_pend = 1'b1;
                                end
                            end
                        end
                    end
                end
                DM_DATA0: sh_data0 = d;
                DM_SBCS:  sh_sbcs  = d;
                DM_SBADDRESS0: begin
                    sh_sbaddress0 = d;
                    if (sh_sbcs[`DM_SBCS_RDONADDR_BIT]) begin
                        sh_mem_addr = d;
                    end
                end
                DM_SBDATA0: begin
                    sh_mem_addr = sh_sbaddress0;
                    if (sh_sbcs[`DM_SBCS_AUTOINC_BIT]) begin
                        sh_sbaddress0 = sh_sbaddress0 + `DM_SB_STEP;
                    end
                end
                default: begin
                end
            endcase
        end
        return {req.addr, rd, {`DM_OP_W{1'b0}}};
    endfunction

    // one DMI transaction; ready comes 0 to 3 cycles into resp
    task automatic dmi_xfer(input dm_addr_e addr, input dm_status_t data, input dmi_op_e op);
        dmi_req_t req;
        int       wait_cnt;
        int       delay;
        req.addr = addr;
        req.data = data;
        req.op   = op;
        exp_q.push_back(ref_resp(req));
        exp_halt_q.push_back(sh_halt);
        delay         = $random(seed) & 3;
        dtm_req_valid = 1'b1;
        dtm_req_data  = req;
        @(negedge clk);
        dtm_req_valid = 1'b0;
        wait_cnt = 0;
        while (!dm_busy) begin
            if (wait_cnt == WAIT_LIMIT) begin
                give_up("busy never rose after a request");
            end
            @(negedge clk);
            wait_cnt++;
        end
        busy_cycles = 0;
        wait_cnt    = 0;
        while (dm_busy) begin
            if (wait_cnt == WAIT_LIMIT) begin
                give_up("busy stayed high, transaction never ended");
            end
            busy_cycles++;
            // the first busy cycle is exe, every later one is resp
            check_bit("dm_op_req_o", op_req, busy_cycles > 1);
            resp_ready = 1'b0;
            if (op_req) begin
                if (delay == 0) begin
                    resp_ready     = 1'b1;
                    seen_reg_we    = reg_we;
                    seen_reg_addr  = reg_addr;
                    seen_reg_wdata = reg_wdata;
                    seen_mem_we    = mem_we;
                    seen_mem_addr  = mem_addr;
                    seen_mem_wdata = mem_wdata;
                end else begin
                    delay--;
                end
            end
            @(negedge clk);
            wait_cnt++;
        end
        resp_ready = 1'b0;
        -> resp_done;
    endtask

    // response compare once busy has fallen
    always begin
        @(resp_done);
        if (exp_q.size() == 0) begin
            give_up("a response arrived with no expected value queued");
        end
        check_resp("dm_resp_data_o", resp_data, exp_q.pop_front());
        check_bit("dm_halt_req_o", halt_req, exp_halt_q.pop_front());
    end

    initial begin
        rst_n         = 1'b0;
        dtm_req_valid = 1'b0;
        dtm_req_data  = '0;
        resp_ready    = 1'b0;
        sh_dmcontrol  = '0;
        sh_dmstatus   = `DM_DMSTATUS_RST;
        sh_abstractcs = `DM_ABSTRACTCS_RST;
        sh_data0      = '0;
        sh_sbcs       = `DM_SBCS_RST;
        sh_sbaddress0 = '0;
        sh_mem_addr   = '0;
        sh_pend       = 1'b0;
        sh_halt       = 1'b0;
        sh_gpr_idx    = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h1000_0000 + i * 32'h0101_0101;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hc0de_0000 | (i << 2);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_bit("dm_busy_o", dm_busy, 1'b0);
        check_bit("dm_op_req_o", op_req, 1'b0);
        check_bit("dm_halt_req_o", halt_req, 1'b0);
        check_bit("dm_reg_we_o", reg_we, 1'b0);
        check_bit("dm_mem_we_o", mem_we, 1'b0);
        dmi_xfer(DM_DMSTATUS, '0, DMI_OP_READ);
        check_word("busy cycles", dm_status_t'(busy_cycles), 32'd1);
        dmi_xfer(DM_ABSTRACTCS, '0, DMI_OP_READ);
        dmi_xfer(DM_SBCS, '0, DMI_OP_READ);
        dmi_xfer(DM_HARTINFO, 32'h1234_5678, DMI_OP_NOP);
        check_word("busy cycles", dm_status_t'(busy_cycles), 32'd1);

        // halt then resume
        dmi_xfer(DM_DMCONTROL, 32'h8000_0001, DMI_OP_WRITE);
        dmi_xfer(DM_DMSTATUS, '0, DMI_OP_READ);
        dmi_xfer(DM_DMCONTROL, 32'h4000_0001, DMI_OP_WRITE);
        dmi_xfer(DM_DMSTATUS, '0, DMI_OP_READ);
        dmi_xfer(DM_DMCONTROL, ($random(seed) & 32'h3fff_ffff) | 32'h1, DMI_OP_WRITE);
        dmi_xfer(DM_DMCONTROL, '0, DMI_OP_READ);

        // gpr writes through data0 and a 32-bit transfer command
        for (int k = 0; k < 3; k++) begin
            wval[k] = $random(seed);
            dmi_xfer(DM_DATA0, wval[k], DMI_OP_WRITE);
            dmi_xfer(DM_COMMAND, 32'h0023_1000 + 3 + k * 9, DMI_OP_WRITE);
            check_bit("dm_reg_we_o", seen_reg_we, 1'b1);
            check_word("dm_reg_addr_o", dm_status_t'(seen_reg_addr), 3 + k * 9);
            check_word("dm_reg_wdata_o", seen_reg_wdata, wval[k]);
            check_word("gpr model", regs[3 + k * 9], wval[k]);
            check_bit("dm_reg_we_o", reg_we, 1'b0);
        end

        // gpr read then a second data0 read that returns data0 itself
        dmi_xfer(DM_COMMAND, 32'h0022_1000 + 7, DMI_OP_WRITE);
        dmi_xfer(DM_DATA0, '0, DMI_OP_READ);
        dmi_xfer(DM_DATA0, '0, DMI_OP_READ);
        dmi_xfer(DM_COMMAND, 32'h0032_1001, DMI_OP_WRITE);
        dmi_xfer(DM_ABSTRACTCS, '0, DMI_OP_READ);

        // system bus with autoincrement
        dmi_xfer(DM_SBCS, `DM_SBCS_RST | (32'h1 << `DM_SBCS_AUTOINC_BIT), DMI_OP_WRITE);
        dmi_xfer(DM_SBADDRESS0, 32'h0000_0040, DMI_OP_WRITE);
        for (int k = 0; k < 2; k++) begin
            wval[k] = $random(seed);
            dmi_xfer(DM_SBDATA0, wval[k], DMI_OP_WRITE);
            check_bit("dm_mem_we_o", seen_mem_we, 1'b1);
            check_word("dm_mem_addr_o", seen_mem_addr, 32'h40 + k * 4);
            check_word("dm_mem_wdata_o", seen_mem_wdata, wval[k]);
            check_word("memory model", mem[16 + k], wval[k]);
        end

        // sbreadonaddr fetches the word for the following sbdata0 read
        dmi_xfer(DM_SBCS, `DM_SBCS_RST | (32'h1 << `DM_SBCS_RDONADDR_BIT), DMI_OP_WRITE);
        dmi_xfer(DM_SBADDRESS0, 32'h0000_0044, DMI_OP_WRITE);
        dmi_xfer(DM_SBDATA0, '0, DMI_OP_READ);
        dmi_xfer(DM_SBADDRESS0, 32'h0000_0088, DMI_OP_WRITE);
        dmi_xfer(DM_SBDATA0, '0, DMI_OP_READ);
        dmi_xfer(DM_SBCS, '0, DMI_OP_READ);

        // debug module reset while halted
        dmi_xfer(DM_DATA0, 32'hdead_beef, DMI_OP_WRITE);
        dmi_xfer(DM_DMCONTROL, 32'h8000_0001, DMI_OP_WRITE);
        dmi_xfer(DM_DMCONTROL, 32'h0000_0000, DMI_OP_WRITE);
        check_bit("dm_halt_req_o", halt_req, 1'b0);
        dmi_xfer(DM_DMSTATUS, '0, DMI_OP_READ);
        dmi_xfer(DM_ABSTRACTCS, '0, DMI_OP_READ);
        dmi_xfer(DM_SBCS, '0, DMI_OP_READ);
        dmi_xfer(DM_DATA0, '0, DMI_OP_READ);

        repeat (2) @(negedge clk);
        if (exp_q.size() != 0) begin
            give_up("expected responses left unchecked");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// ==== riscv_dm.f ====
+incdir+logic
logic/dm_pkg.sv
logic/dmi_cmd_if.sv
logic/dm_csr_if.sv
logic/dmi_decode.sv
logic/dm_debug_regs.sv
logic/dm_resp.sv
logic/riscv_dm_top.sv
verif/riscv_dm_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_dm

sources:
  - include_dirs:
      - logic
    files:
      - logic/dm_pkg.sv
      - logic/dmi_cmd_if.sv
      - logic/dm_csr_if.sv
      - logic/dmi_decode.sv
      - logic/dm_debug_regs.sv
      - logic/dm_resp.sv
      - logic/riscv_dm_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verif/riscv_dm_tb.sv
